/* tb.f */
+incdir+.
avl_pcie_tx_pkg.sv
sync_fifo.sv
a2p_addr_trans.sv
avl_req_ctrl.sv
tlp_tx_engine.sv
avl_pcie_tx.sv
tb_avl_pcie_tx.sv

/* Makefile */
# Verilator build and run of the transmit bridge testbench
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ns
TOP      := tb_avl_pcie_tx
FILELIST := tb.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) avl_pcie_tx_defines.svh

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status follows the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* tb_avl_pcie_tx.sv */
/*
  Directed testbench for the Avalon-to-PCIe transmit bridge. A reference
  model queues the expected stream beats for each request and a monitor
  checks every accepted beat, and that beats hold while ready is low.
*/
`timescale 1ns/1ns
`include "avl_pcie_tx_defines.svh"

module tb_avl_pcie_tx;

  localparam int CLK_PERIOD  = 8;
  localparam int N_RAND      = 30;
  localparam int N_FILL      = 16;
  localparam int BEAT_BUDGET = 14 + N_RAND * 9 + N_FILL * 5;   // Upper bound on beats
  localparam int WATCHDOG_NS = (BEAT_BUDGET * 8 + 600) * CLK_PERIOD;
  localparam logic [12:0] BUS_DEV = 13'h0A5;

  typedef logic [131:0] cmp_t;

  // One beat as seen on the stream
  typedef struct packed {
    logic [`AVL_DATA_W-1:0] data;
    logic                   sop;
    logic                   eop;
    logic [1:0]             empty;
  } st_beat_t;

  logic                     Clk_i = 1'b0;
  logic                     Rstn_i;
  logic                     TxChipSelect_i;
  logic                     TxRead_i;
  logic                     TxWrite_i;
  logic [`AVL_ADDR_W-1:0]   TxAddress_i;
  logic [`BURST_W-1:0]      TxBurstCount_i;
  logic [`AVL_DATA_W/8-1:0] TxByteEnable_i;
  logic [`AVL_DATA_W-1:0]   TxWriteData_i;
  logic                     TxWaitRequest_o;
  logic [12:0]              BusDev_i;
  logic                     TxStReady_i;
  logic [`AVL_DATA_W-1:0]   TxStData_o;
  logic                     TxStSop_o;
  logic                     TxStEop_o;
  logic [1:0]               TxStEmpty_o;
  logic                     TxStValid_o;
  logic                     TxBufferEmpty_o;

  logic [1:0]         ready_mode = 2'd1;   // 0 low, 1 high, 2 random
  logic [`TAG_W-1:0]  rd_tag;
  st_beat_t           exp_q[$];
  st_beat_t           held;
  logic               held_vld = 1'b0;

  avl_pcie_tx UUT (.*);

  always #(CLK_PERIOD / 2) Clk_i = ~Clk_i;

  task automatic check_equal(input cmp_t got, input cmp_t exp, input string what);
    if (got !== exp)
    begin
      $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Table lookup followed by the pass-through bits
  function automatic logic [63:0] translate(input logic [`AVL_ADDR_W-1:0] addr);
    logic [63:0] base;
    case (addr[`AVL_ADDR_W-1:`A2P_PASS_BITS])
      2'd0:    base = `A2P_ENTRY0;
      2'd1:    base = `A2P_ENTRY1;
      2'd2:    base = `A2P_ENTRY2;
      default: base = `A2P_ENTRY3;
    endcase
    return {base[63:`A2P_PASS_BITS], addr[`A2P_PASS_BITS-1:0]};
  endfunction

  task automatic queue_header(input logic wr, input logic [`AVL_ADDR_W-1:0] addr,
                              input int beats, input logic [15:0] be,
                              input logic [`TAG_W-1:0] tag);
    logic [63:0]  pa;
    logic         is64;
    logic [2:0]   fmt;
    logic [31:0]  dw0;
    logic [31:0]  dw1;
    logic [127:0] hdr;
    pa   = translate(addr);
    is64 = (pa[63:32] != 32'd0);
    fmt  = wr ? (is64 ? 3'd3 : 3'd2) : (is64 ? 3'd1 : 3'd0);
    dw0  = {fmt, 5'd0, 14'd0, 10'(beats * 4)};   // Type 0
    dw1  = {BUS_DEV, 3'b000, 3'b000, tag, be[15:12], be[3:0]};
    hdr  = is64 ? {pa[31:0], pa[63:32], dw1, dw0} : {32'd0, pa[31:0], dw1, dw0};
    exp_q.push_back({hdr, 1'b1, ~wr, is64 ? 2'd0 : 2'd1});
  endtask

  // Returns just after the edge where the beat was taken
  task automatic wait_accept();
    @(posedge Clk_i);
    while (TxWaitRequest_o)
      @(posedge Clk_i);
    #1;
  endtask

  task automatic idle_bus();
    TxChipSelect_i = 1'b0;
    TxWrite_i      = 1'b0;
    TxRead_i       = 1'b0;
  endtask

  task automatic avl_write(input logic [`AVL_ADDR_W-1:0] addr, input int beats,
                           input logic [15:0] be);
    logic [127:0] dq[$];
    int           i;
    for (i = 0; i < beats; i++)
      dq.push_back({$urandom, $urandom, $urandom, $urandom});
    queue_header(1'b1, addr, beats, be, '0);   // Posted writes carry tag 0
    for (i = 0; i < beats; i++)
      exp_q.push_back({dq[i], 1'b0, (i == beats - 1), 2'd0});
    for (i = 0; i < beats; i++)
    begin
      TxChipSelect_i = 1'b1;
      TxWrite_i      = 1'b1;
      TxAddress_i    = addr;
      TxBurstCount_i = `BURST_W'(beats);
      TxByteEnable_i = be;
      TxWriteData_i  = dq[i];
      wait_accept();
    end
    idle_bus();
  endtask

  task automatic avl_read(input logic [`AVL_ADDR_W-1:0] addr, input logic [15:0] be);
    queue_header(1'b0, addr, 1, be, rd_tag);
    rd_tag         = rd_tag + 1'b1;
    TxChipSelect_i = 1'b1;
    TxRead_i       = 1'b1;
    TxAddress_i    = addr;
    TxBurstCount_i = `BURST_W'(1);
    TxByteEnable_i = be;
    wait_accept();
    idle_bus();
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || !TxBufferEmpty_o) && n < max_cycles)
    begin
      @(posedge Clk_i);
      #1;
      n++;
    end
    if (exp_q.size() != 0 || !TxBufferEmpty_o)
    begin
      $display("Stream did not drain within %0d cycles at %0t ns", max_cycles, $time);
      $display("RESULT: FAIL");
      $fatal(1, "Drain timeout");
    end
  endtask

  task automatic test_single_write();
    avl_write(24'h01_2340, 1, 16'hF00E);   // Entry 0 with partial enables
    wait_drain(200);
  endtask

  task automatic test_burst_4dw();
    avl_write(24'hC0_1000, 8, 16'hFFFF);   // Entry 3 sits above 4 GB
    wait_drain(400);
  endtask

  task automatic test_read_tags();
    avl_read(24'h40_0010, 16'h000F);
    avl_read(24'hC0_0100, 16'hFFFF);
    avl_read(24'h81_2340, 16'hF00F);
    wait_drain(300);
  endtask

  task automatic test_random_ready();
    logic [`AVL_ADDR_W-1:0] addr;
    int                     n;
    ready_mode = 2'd2;
    for (n = 0; n < N_RAND; n++)
    begin
      addr = 24'($urandom) & 24'hFF_FFF0;
      if ($urandom % 3 == 0)
        avl_read(addr, 16'($urandom));
      else
        avl_write(addr, 1 + int'($urandom % 8), 16'($urandom));
    end
    wait_drain(N_RAND * 60);
    ready_mode = 2'd1;
  endtask

  task automatic test_backlog();
    int n;
    int stuck;
    int cyc;
    ready_mode = 2'd0;
    fork
      begin
        for (n = 0; n < N_FILL; n++)
          avl_write(24'h00_0100 + 24'(n * 64), 4, 16'hFFFF);
      end
      begin
        stuck = 0;
        cyc   = 0;
        while (stuck < 20 && cyc < 2000)
        begin
          @(posedge Clk_i);
          stuck = TxWaitRequest_o ? stuck + 1 : 0;
          cyc++;
        end
        if (stuck < 20)
        begin
          $display("Waitrequest never stayed high with the stream stalled");
          $display("RESULT: FAIL");
          $fatal(1, "No back-pressure");
        end
        else
          ready_mode = 2'd1;   // Let the queued TLPs out
      end
    join
    wait_drain(N_FILL * 40);
    check_equal(cmp_t'(TxWaitRequest_o), cmp_t'(0), "waitrequest after recovery");
  endtask

  // Stream ready driven just after each rising edge
  initial
  begin
    TxStReady_i = 1'b0;
    forever
    begin
      @(posedge Clk_i);
      #1;
      case (ready_mode)
        2'd0:    TxStReady_i = 1'b0;
        2'd1:    TxStReady_i = 1'b1;
        default: TxStReady_i = 1'($urandom);
      endcase
    end
  end

  always @(posedge Clk_i)
  begin : monitor
    st_beat_t got;
    st_beat_t exp;
    got = {TxStData_o, TxStSop_o, TxStEop_o, TxStEmpty_o};
    if (held_vld)
    begin
      check_equal(cmp_t'(TxStValid_o), cmp_t'(1), "valid dropped while held");
      check_equal(cmp_t'(got), cmp_t'(held), "beat changed while held");
    end
    if (Rstn_i && TxStValid_o && TxStReady_i)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Stream beat at %0t ns with no request pending", $time);
        $display("RESULT: FAIL");
        $fatal(1, "Unexpected beat");
      end
      else
      begin
        exp = exp_q.pop_front();
        check_equal(cmp_t'(got.data), cmp_t'(exp.data), "beat data");
        check_equal(cmp_t'(got.sop), cmp_t'(exp.sop), "sop");
        check_equal(cmp_t'(got.eop), cmp_t'(exp.eop), "eop");
        check_equal(cmp_t'(got.empty), cmp_t'(exp.empty), "empty");
      end
    end
    held_vld = Rstn_i & TxStValid_o & ~TxStReady_i;
    held     = got;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout, run still going after %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial
  begin
    void'($urandom(67032));
    Rstn_i         = 1'b0;
    TxAddress_i    = '0;
    TxBurstCount_i = '0;
    TxByteEnable_i = '0;
    TxWriteData_i  = '0;
    BusDev_i       = BUS_DEV;
    rd_tag         = '0;
    idle_bus();
    @(posedge Clk_i);
    repeat (7)
    begin
      @(posedge Clk_i);
      check_equal(cmp_t'(TxStValid_o), cmp_t'(0), "valid during reset");
      check_equal(cmp_t'(TxWaitRequest_o), cmp_t'(1), "waitrequest during reset");
    end
    #1;
    Rstn_i = 1'b1;
    check_equal(cmp_t'(TxWaitRequest_o), cmp_t'(1), "waitrequest before first clock");
    @(posedge Clk_i);
    #1;
    check_equal(cmp_t'(TxWaitRequest_o), cmp_t'(0), "waitrequest after first clock");
    test_single_write();
    test_burst_4dw();
    test_read_tags();
    test_random_ready();
    test_backlog();
    repeat (4) @(posedge Clk_i);
    if (exp_q.size() != 0)
    begin
      $display("%0d expected beats never appeared", exp_q.size());
      $display("RESULT: FAIL");
      $fatal(1, "Missing beats");
    end
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

/* avl_pcie_tx.sv */
/*
  Transmit side of the Avalon-to-PCIe bridge. Avalon requests are
  translated, queued as commands plus write data, and sent as memory
  read and write TLPs on the 128-bit stream toward the PCIe core.
*/
`timescale 1ns/1ns
`include "avl_pcie_tx_defines.svh"

module avl_pcie_tx
  import avl_pcie_tx_pkg::*;
(
  input  logic                     Clk_i,
  input  logic                     Rstn_i,
  input  logic                     TxChipSelect_i,
  input  logic                     TxRead_i,
  input  logic                     TxWrite_i,
  input  logic [`AVL_ADDR_W-1:0]   TxAddress_i,
  input  logic [`BURST_W-1:0]      TxBurstCount_i,
  input  logic [`AVL_DATA_W/8-1:0] TxByteEnable_i,
  input  logic [`AVL_DATA_W-1:0]   TxWriteData_i,
  output logic                     TxWaitRequest_o,
  input  logic [12:0]              BusDev_i,
  input  logic                     TxStReady_i,
  output logic [`AVL_DATA_W-1:0]   TxStData_o,
  output logic                     TxStSop_o,
  output logic                     TxStEop_o,
  output logic [1:0]               TxStEmpty_o,
  output logic                     TxStValid_o,
  output logic                     TxBufferEmpty_o   // Command FIFO empty
);

  localparam int CMD_CNT_W = $clog2(`CMD_FIFO_DEPTH + 1);
  localparam int WRD_CNT_W = $clog2(`WRDAT_FIFO_DEPTH + 1);

  logic                   avl_addr_vld;
  logic [`AVL_ADDR_W-1:0] avl_addr;
  logic                   pci_addr_vld;
  pcie_addr_t             pci_addr;
  logic                   cmd_fifo_wrreq;
  logic                   cmd_fifo_rdreq;
  tx_cmd_t                cmd_fifo_din;
  tx_cmd_t                cmd_fifo_dout;
  logic [CMD_CNT_W-1:0]   cmd_fifo_usedw;
  logic                   wrdat_fifo_wrreq;
  logic                   wrdat_fifo_rdreq;
  wr_beat_t               wrdat_fifo_din;
  wr_beat_t               wrdat_fifo_dout;
  logic                   wrdat_fifo_empty;
  logic [WRD_CNT_W-1:0]   wrdat_fifo_usedw;

  avl_req_ctrl u_req_ctrl (
    .Clk_i, .Rstn_i, .TxChipSelect_i, .TxRead_i, .TxWrite_i, .TxAddress_i,
    .TxBurstCount_i, .TxByteEnable_i, .TxWriteData_i, .TxWaitRequest_o,
    .CmdFifoUsedW_i(cmd_fifo_usedw), .WrDatFifoUsedW_i(wrdat_fifo_usedw),
    .AvlAddrVld_o(avl_addr_vld), .AvlAddr_o(avl_addr),
    .PciAddrVld_i(pci_addr_vld), .PciAddr_i(pci_addr),
    .CmdFifoWrReq_o(cmd_fifo_wrreq), .CmdFifoDat_o(cmd_fifo_din),
    .WrDatFifoWrReq_o(wrdat_fifo_wrreq), .WrDatFifoDat_o(wrdat_fifo_din)
  );

  a2p_addr_trans u_addr_trans (
    .Clk_i, .Rstn_i,
    .AvlAddrVld_i(avl_addr_vld), .AvlAddr_i(avl_addr),
    .PciAddrVld_o(pci_addr_vld), .PciAddr_o(pci_addr)
  );

  sync_fifo #(.T_PAYLOAD(tx_cmd_t), .DEPTH(`CMD_FIFO_DEPTH)) u_cmd_fifo (
    .Clk_i, .Rstn_i, .WrReq_i(cmd_fifo_wrreq), .Dat_i(cmd_fifo_din),
    .RdReq_i(cmd_fifo_rdreq), .Dat_o(cmd_fifo_dout),
    .Empty_o(TxBufferEmpty_o), .UsedW_o(cmd_fifo_usedw)
  );

  sync_fifo #(.T_PAYLOAD(wr_beat_t), .DEPTH(`WRDAT_FIFO_DEPTH)) u_wrdat_fifo (
    .Clk_i, .Rstn_i, .WrReq_i(wrdat_fifo_wrreq), .Dat_i(wrdat_fifo_din),
    .RdReq_i(wrdat_fifo_rdreq), .Dat_o(wrdat_fifo_dout),
    .Empty_o(wrdat_fifo_empty), .UsedW_o(wrdat_fifo_usedw)
  );

  tlp_tx_engine u_tx_engine (
    .Clk_i, .Rstn_i, .BusDev_i,
    .CmdFifoEmpty_i(TxBufferEmpty_o), .CmdFifoDat_i(cmd_fifo_dout),
    .CmdFifoRdReq_o(cmd_fifo_rdreq),
    .WrDatFifoEmpty_i(wrdat_fifo_empty), .WrDatFifoDat_i(wrdat_fifo_dout),
    .WrDatFifoRdReq_o(wrdat_fifo_rdreq),
    .TxStReady_i, .TxStData_o, .TxStSop_o, .TxStEop_o, .TxStEmpty_o, .TxStValid_o
  );

endmodule

/* tlp_tx_engine.sv */
/*
  Transmit engine. Pops one command at a time, sends its header beat and
  then the write data beats on the 128-bit stream. Ready latency is zero;
  the output stage holds while TxStReady_i is low.
*/
`timescale 1ns/1ns
`include "avl_pcie_tx_defines.svh"

module tlp_tx_engine
  import avl_pcie_tx_pkg::*;
(
  input  logic                   Clk_i,
  input  logic                   Rstn_i,
  input  logic [12:0]            BusDev_i,
  input  logic                   CmdFifoEmpty_i,
  input  tx_cmd_t                CmdFifoDat_i,
  output logic                   CmdFifoRdReq_o,
  input  logic                   WrDatFifoEmpty_i,
  input  wr_beat_t               WrDatFifoDat_i,
  output logic                   WrDatFifoRdReq_o,
  input  logic                   TxStReady_i,
  output logic [`AVL_DATA_W-1:0] TxStData_o,
  output logic                   TxStSop_o,
  output logic                   TxStEop_o,
  output logic [1:0]             TxStEmpty_o,
  output logic                   TxStValid_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_HDR, ST_DATA} tx_state_e;

  tx_state_e              state;
  tx_state_e              state_nxt;
  logic [`AVL_DATA_W-1:0] hdr_q;
  logic [31:0]            dw0;
  logic [31:0]            dw1;
  logic [31:0]            dw2;
  logic [31:0]            dw3;
  logic [`BURST_W-1:0]    pop_left;   // Data beats not yet popped
  logic                   pop_pend;   // FIFO output holds a fresh beat
  logic                   dbuf_vld;
  wr_beat_t               dbuf;
  wr_beat_t               src_beat;
  logic                   src_vld;
  logic                   can_load;
  logic                   load_hdr;
  logic                   load_dat;

  assign can_load = ~TxStValid_o | TxStReady_i;
  assign src_vld  = dbuf_vld | pop_pend;   // Never both at once
  assign src_beat = dbuf_vld ? dbuf : WrDatFifoDat_i;
  assign load_hdr = (state == ST_HDR) & can_load;
  assign load_dat = (state == ST_DATA) & src_vld & can_load;

  assign CmdFifoRdReq_o = (state == ST_IDLE) & ~CmdFifoEmpty_i;

  // Prefetch only when the beat in hand leaves this cycle
  assign WrDatFifoRdReq_o = ((state == ST_HDR) | (state == ST_DATA)) &
                            (pop_left != '0) & ~WrDatFifoEmpty_i &
                            ~(src_vld & ~load_dat);

  // Header DWs, fmt is {is_write, is_64}
  always_comb
  begin
    dw0 = {1'b0, CmdFifoDat_i.is_write, CmdFifoDat_i.addr.is_64, 19'd0,
           CmdFifoDat_i.len_dw};
    dw1 = {BusDev_i, 3'b000, {(8-`TAG_W){1'b0}}, CmdFifoDat_i.tag,
           CmdFifoDat_i.last_be, CmdFifoDat_i.first_be};
    dw2 = CmdFifoDat_i.addr.is_64 ? CmdFifoDat_i.addr.addr[63:32]
                                  : CmdFifoDat_i.addr.addr[31:0];
    dw3 = CmdFifoDat_i.addr.is_64 ? CmdFifoDat_i.addr.addr[31:0] : 32'd0;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (~CmdFifoEmpty_i) state_nxt = ST_FETCH;
      ST_FETCH: state_nxt = ST_HDR;   // Command now on the FIFO output
      ST_HDR:   if (can_load) state_nxt = CmdFifoDat_i.is_write ? ST_DATA : ST_IDLE;
      ST_DATA:  if (load_dat && src_beat.eop) state_nxt = ST_IDLE;
      default:  state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state       <= ST_IDLE;
      pop_left    <= '0;
      pop_pend    <= 1'b0;
      dbuf_vld    <= 1'b0;
      TxStValid_o <= 1'b0;
      TxStSop_o   <= 1'b0;
      TxStEop_o   <= 1'b0;
      TxStEmpty_o <= 2'd0;
    end
    else
    begin
      state    <= state_nxt;
      pop_pend <= WrDatFifoRdReq_o;
      if (state == ST_FETCH)
        pop_left <= CmdFifoDat_i.is_write ? CmdFifoDat_i.len_dw[`BURST_W+1:2] : '0;
      else if (WrDatFifoRdReq_o)
        pop_left <= pop_left - 1'b1;
      if (pop_pend & ~load_dat)
        dbuf_vld <= 1'b1;   // Output stalled, park the beat
      else if (load_dat)
        dbuf_vld <= 1'b0;
      if (can_load)
      begin
        TxStValid_o <= load_hdr | load_dat;
        TxStSop_o   <= load_hdr;
        TxStEop_o   <= load_hdr ? ~CmdFifoDat_i.is_write : src_beat.eop;
        TxStEmpty_o <= (load_hdr & ~CmdFifoDat_i.addr.is_64) ? 2'd1 : 2'd0;
      end
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (state == ST_FETCH)
      hdr_q <= {dw3, dw2, dw1, dw0};
    if (pop_pend & ~load_dat)
      dbuf <= WrDatFifoDat_i;
    if (can_load)
      TxStData_o <= load_hdr ? hdr_q : src_beat.data;
  end

endmodule

/* avl_req_ctrl.sv */
/*
  Avalon slave of the transmit bridge. Accepts burst writes and single
  reads, pushes write beats into the data FIFO right away and builds one
  command per request once its translated address comes back.
*/
`timescale 1ns/1ns
`include "avl_pcie_tx_defines.svh"

module avl_req_ctrl
  import avl_pcie_tx_pkg::*;
(
  input  logic                             Clk_i,
  input  logic                             Rstn_i,
  input  logic                             TxChipSelect_i,
  input  logic                             TxRead_i,
  input  logic                             TxWrite_i,
  input  logic [`AVL_ADDR_W-1:0]           TxAddress_i,
  input  logic [`BURST_W-1:0]              TxBurstCount_i,
  input  logic [`AVL_DATA_W/8-1:0]         TxByteEnable_i,
  input  logic [`AVL_DATA_W-1:0]           TxWriteData_i,
  output logic                             TxWaitRequest_o,
  input  logic [$clog2(`CMD_FIFO_DEPTH+1)-1:0]   CmdFifoUsedW_i,
  input  logic [$clog2(`WRDAT_FIFO_DEPTH+1)-1:0] WrDatFifoUsedW_i,
  output logic                             AvlAddrVld_o,
  output logic [`AVL_ADDR_W-1:0]           AvlAddr_o,
  input  logic                             PciAddrVld_i,
  input  pcie_addr_t                       PciAddr_i,
  output logic                             CmdFifoWrReq_o,
  output tx_cmd_t                          CmdFifoDat_o,
  output logic                             WrDatFifoWrReq_o,
  output wr_beat_t                         WrDatFifoDat_o
);

  logic                init_done;    // Set on the first clock after reset
  logic [`BURST_W-1:0] beats_left;   // Beats still owed by an open burst
  logic                burst_open;
  logic                cmd_room;
  logic                dat_room;
  logic                accept;
  logic                wr_beat;
  logic                first_wr;
  logic                rd_req;
  logic [`TAG_W-1:0]   tag_q;

  // Command fields waiting for the translator
  logic                pend_wr;
  logic [9:0]          pend_len;
  logic [3:0]          pend_fbe;
  logic [3:0]          pend_lbe;
  logic [`TAG_W-1:0]   pend_tag;

  assign burst_open = (beats_left != '0);
  assign cmd_room   = int'(CmdFifoUsedW_i) <= `CMD_FIFO_DEPTH - 2;
  assign dat_room   = int'(WrDatFifoUsedW_i) <= `WRDAT_FIFO_DEPTH - `MAX_BURST;

  // Master may not start a new request inside a burst
  assign TxWaitRequest_o = ~init_done | ~cmd_room | ~dat_room |
                           (burst_open & ~(TxChipSelect_i & TxWrite_i));

  assign accept   = TxChipSelect_i & (TxWrite_i | TxRead_i) & ~TxWaitRequest_o;
  assign wr_beat  = accept & TxWrite_i;
  assign first_wr = wr_beat & ~burst_open;
  assign rd_req   = accept & ~TxWrite_i & ~burst_open;

  assign AvlAddrVld_o = first_wr | rd_req;
  assign AvlAddr_o    = TxAddress_i;

  assign WrDatFifoWrReq_o    = wr_beat;
  assign WrDatFifoDat_o.data = TxWriteData_i;
  assign WrDatFifoDat_o.eop  = burst_open ? (beats_left == `BURST_W'(1))
                                          : (TxBurstCount_i == `BURST_W'(1));

  // Command goes out with the translated address
  assign CmdFifoWrReq_o = PciAddrVld_i;
  always_comb
  begin
    CmdFifoDat_o.is_write = pend_wr;
    CmdFifoDat_o.len_dw   = pend_len;
    CmdFifoDat_o.first_be = pend_fbe;
    CmdFifoDat_o.last_be  = pend_lbe;
    CmdFifoDat_o.tag      = pend_tag;
    CmdFifoDat_o.addr     = PciAddr_i;
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      init_done  <= 1'b0;
      beats_left <= '0;
      tag_q      <= '0;
    end
    else
    begin
      init_done <= 1'b1;
      if (first_wr)
        beats_left <= TxBurstCount_i - 1'b1;
      else if (wr_beat)
        beats_left <= beats_left - 1'b1;
      if (rd_req)
        tag_q <= tag_q + 1'b1;   // Wraps at 32
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (first_wr | rd_req)
    begin
      pend_wr  <= first_wr;
      pend_len <= first_wr ? 10'({TxBurstCount_i, 2'b00}) : 10'd4;
      pend_fbe <= TxByteEnable_i[3:0];
      pend_lbe <= TxByteEnable_i[15:12];
      pend_tag <= first_wr ? '0 : tag_q;   // Writes carry tag 0
    end
  end

endmodule

/* a2p_addr_trans.sv */
/*
  Fixed-table Avalon-to-PCIe address translation. The bits above the
  pass-through field pick a table base; the result is registered, so
  PciAddrVld_o follows AvlAddrVld_i by exactly one cycle.
*/
`timescale 1ns/1ns
`include "avl_pcie_tx_defines.svh"

module a2p_addr_trans
  import avl_pcie_tx_pkg::*;
(
  input  logic                   Clk_i,
  input  logic                   Rstn_i,
  input  logic                   AvlAddrVld_i,
  input  logic [`AVL_ADDR_W-1:0] AvlAddr_i,
  output logic                   PciAddrVld_o,
  output pcie_addr_t             PciAddr_o
);

  localparam int PB = `A2P_PASS_BITS;

  logic [`AVL_ADDR_W-PB-1:0] sel;
  logic [63:0]               base;
  logic [63:0]               merged;

  assign sel    = AvlAddr_i[`AVL_ADDR_W-1:PB];
  assign merged = {base[63:PB], AvlAddr_i[PB-1:0]};

  always_comb
  begin
    case (sel)
      2'd0:    base = `A2P_ENTRY0;
      2'd1:    base = `A2P_ENTRY1;
      2'd2:    base = `A2P_ENTRY2;
      default: base = `A2P_ENTRY3;
    endcase
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      PciAddrVld_o <= 1'b0;
    else
      PciAddrVld_o <= AvlAddrVld_i;
  end

  always_ff @(posedge Clk_i)
  begin
    if (AvlAddrVld_i)
    begin
      PciAddr_o.addr  <= merged;
      PciAddr_o.is_64 <= |merged[63:32];   // Selects the 4DW header later
    end
  end

endmodule

/* sync_fifo.sv */
/*
  Single-clock FIFO for any payload type. The output register loads on a
  pop, so the popped entry shows on Dat_o one cycle later. UsedW_o counts
  the stored entries.
*/
`timescale 1ns/1ns

module sync_fifo #(
  parameter type T_PAYLOAD = logic,
  parameter int  DEPTH     = 16
) (
  input  logic                       Clk_i,
  input  logic                       Rstn_i,
  input  logic                       WrReq_i,
  input  T_PAYLOAD                   Dat_i,
  input  logic                       RdReq_i,
  output T_PAYLOAD                   Dat_o,
  output logic                       Empty_o,
  output logic [$clog2(DEPTH+1)-1:0] UsedW_o
);

  localparam int AW = $clog2(DEPTH);

  T_PAYLOAD      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;

  assign Empty_o = (UsedW_o == '0);

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      UsedW_o <= '0;
    end
    else
    begin
      if (WrReq_i)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (RdReq_i)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({WrReq_i, RdReq_i})
        2'b10:   UsedW_o <= UsedW_o + 1'b1;
        2'b01:   UsedW_o <= UsedW_o - 1'b1;
        default: UsedW_o <= UsedW_o;   // Both or neither
      endcase
    end
  end

  // Storage and output register
  always_ff @(posedge Clk_i)
  begin
    if (WrReq_i)
      mem[wr_ptr] <= Dat_i;
    if (RdReq_i)
      Dat_o <= mem[rd_ptr];
  end

endmodule

/* avl_pcie_tx_pkg.sv */
/*
  Types shared by the Avalon-to-PCIe transmit bridge: translated
  addresses, queued commands and write data beats.
*/
`include "avl_pcie_tx_defines.svh"

package avl_pcie_tx_pkg;

  // Result of the address translation
  typedef struct packed {
    logic [63:0] addr;
    logic        is_64;    // Upper half non-zero
  } pcie_addr_t;

  // One request waiting in the command FIFO
  typedef struct packed {
    logic                is_write;
    logic [9:0]          len_dw;   // TLP length field
    logic [3:0]          first_be;
    logic [3:0]          last_be;
    logic [`TAG_W-1:0]   tag;
    pcie_addr_t          addr;
  } tx_cmd_t;

  // One write data beat
  typedef struct packed {
    logic [`AVL_DATA_W-1:0] data;
    logic                   eop;   // Last beat of the burst
  } wr_beat_t;

endpackage

/* avl_pcie_tx_defines.svh */
/*
  Widths, queue depths and the fixed Avalon-to-PCIe translation table
  of the transmit bridge. Included by the package and by the RTL modules.
*/
`ifndef AVL_PCIE_TX_DEFINES_SVH
`define AVL_PCIE_TX_DEFINES_SVH

`define AVL_ADDR_W        24   // Avalon byte address
`define AVL_DATA_W        128
`define BURST_W           6
`define MAX_BURST         32   // Beats, also the data room kept free

// Low address bits passed straight through, upper two bits pick an entry
`define A2P_PASS_BITS     22

// Table bases, aligned above the pass-through field
`define A2P_ENTRY0        64'h0000_0000_1000_0000
`define A2P_ENTRY1        64'h0000_0000_2040_0000
`define A2P_ENTRY2        64'h0000_0000_C000_0000
`define A2P_ENTRY3        64'h0000_0012_3480_0000   // Needs a 4DW header

`define CMD_FIFO_DEPTH    16
`define WRDAT_FIFO_DEPTH  64

`define TAG_W             5

`endif
